// File: sim.f
+incdir+bench
hdl/core_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/echo_fifo.sv
hdl/fpga_core.sv
bench/tb_fpga_core.sv

// File: bench/tb_uart_host.svh
// host-side uart tasks: frame sender, echo receiver, lfsr byte source, expected-echo queue.
`ifndef TB_UART_HOST_SVH
`define TB_UART_HOST_SVH

core_pkg::uart_byte_t expected_q[$];          // echoes still owed by the dut.
logic [15:0]          lfsr_state = 16'd29590;  // galois lfsr state, fixed seed.

// one galois step, x^16 + x^14 + x^13 + x^11 + 1, returns the bit shifted out.
function automatic logic lfsr_bit();
    logic out_bit;
    out_bit    = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit) begin
        lfsr_state = lfsr_state ^ 16'hB400;  // feed the taps.
    end
    return out_bit;
endfunction

// eight steps, one per bit of the byte.
function automatic core_pkg::uart_byte_t random_byte();
    core_pkg::uart_byte_t value;
    for (int i = 0; i < 8; i++) begin
        value[i] = lfsr_bit();
    end
    return value;
endfunction

// drives one 8n1 frame on uart_txd, lsb first.
task automatic send_byte(input core_pkg::uart_byte_t data, input logic stop_level);
    logic [9:0] frame;
    frame = {stop_level, data, 1'b0};  // stop, data, start.
    for (int i = 0; i < 10; i++) begin
        @(posedge clk);
        #2;
        uart_txd = frame[i];
        repeat (BIT_CYCLES - 1) @(posedge clk);
    end
    // a low stop bit needs an idle bit so the next start has an edge.
    if (!stop_level) begin
        @(posedge clk);
        #2;
        uart_txd = 1'b1;
        repeat (BIT_CYCLES - 1) @(posedge clk);
    end
endtask

// waits up to window cycles for a start edge on uart_rxd, then samples mid-bit.
task automatic receive_byte(input int window, output core_pkg::uart_byte_t data,
                            output logic found);
    int waited;
    waited = 0;
    found  = 1'b0;
    data   = '0;
    while (!found && (waited < window)) begin
        @(negedge clk);  // away from the dut's output edge.
        waited++;
        found = (uart_rxd === 1'b0);
    end
    if (found) begin
        repeat (BIT_CYCLES / 2) @(negedge clk);
        if (uart_rxd !== 1'b0) begin
            report_fail("start bit on uart_rxd did not last until mid-bit");
        end
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CYCLES) @(negedge clk);
            data[i] = uart_rxd;
        end
        repeat (BIT_CYCLES) @(negedge clk);
        if (uart_rxd !== 1'b1) begin
            report_fail("stop bit on uart_rxd was low");
        end
    end
endtask

`endif

// File: bench/tb_fpga_core.sv
// testbench for fpga_core with clock, reset, dut, timeout, compare tasks and directed tests.
`timescale 1ns/10ps
`default_nettype none

module tb_fpga_core;

    localparam int BIT_CYCLES     = int'(core_pkg::PRESCALE) * 8;  // 1080 clocks per bit.
    localparam int FRAME_CYCLES   = BIT_CYCLES * 10;               // one 8n1 byte.
    localparam int ECHO_WINDOW    = FRAME_CYCLES * 3;              // wait for an echo start.
    localparam int TIMEOUT_CYCLES = 1_500_000;  // ~95 byte times of run plus margin.

    logic       clk;
    logic       rst_n;
    logic       btn;
    logic [7:0] sw;
    logic [7:0] led;
    logic       uart_txd;        // host to dut.
    logic       uart_rxd;        // dut to host.
    logic       uart_rts;
    logic       uart_cts;
    int         cycle_count = 0;
    logic       line_must_idle;  // set while rts holds the transmitter off.

    fpga_core fpga_core_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .btn      (btn),
        .sw       (sw),
        .led      (led),
        .uart_txd (uart_txd),
        .uart_rxd (uart_rxd),
        .uart_rts (uart_rts),
        .uart_cts (uart_cts)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;  // 20 ns period.

    task automatic report_fail(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_byte(input string name, input core_pkg::uart_byte_t expected,
                              input core_pkg::uart_byte_t actual);
        if (actual !== expected) begin
            report_fail($sformatf("error %s expected %h got %h", name, expected, actual));
        end
    endtask

    // led is combinational from btn and sw and is read on the falling edge.
    task automatic check_led(input logic [7:0] expected);
        @(negedge clk);
        if (led !== expected) begin
            report_fail($sformatf("error led expected %h got %h", expected, led));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_fail($sformatf("error %s expected %h got %h", name, expected, actual));
        end
    endtask

    `include "tb_uart_host.svh"

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_fail("timeout, the tests did not finish within the cycle limit");
        end
    end

    // no start bit may leave the core while the host holds rts high.
    always @(negedge clk) begin
        if (line_must_idle && (uart_rxd !== 1'b1)) begin
            report_fail("a byte started on uart_rxd while rts was high");
        end
    end

    task automatic set_rts(input logic level);
        @(posedge clk);
        #2;
        uart_rts       = level;
        line_must_idle = level;
    endtask

    // pops one expected byte per echo in order.
    task automatic expect_echoes(input int count);
        core_pkg::uart_byte_t got;
        logic                 found;
        for (int i = 0; i < count; i++) begin
            receive_byte(ECHO_WINDOW, got, found);
            if (!found) begin
                report_fail($sformatf("echo %0d of %0d never started on uart_rxd",
                                      i + 1, count));
            end
            if (expected_q.size() == 0) begin
                report_fail("a byte came back on uart_rxd with none outstanding");
            end
            check_byte("uart_rxd", expected_q.pop_front(), got);
        end
    endtask

    task automatic expect_quiet();
        core_pkg::uart_byte_t got;
        logic                 found;
        receive_byte(FRAME_CYCLES * 2, got, found);
        if (found) begin
            report_fail("an extra byte was echoed on uart_rxd");
        end
    endtask

    task automatic test_gpio();
        core_pkg::uart_byte_t value;
        @(negedge clk);
        check_flag("uart_rxd", 1'b1, uart_rxd);  // idle line after reset.
        check_flag("uart_cts", 1'b0, uart_cts);
        check_led(sw);
        repeat (6) begin
            @(posedge clk);
            #2;
            sw = random_byte();
            check_led(sw);
        end
        value = random_byte();
        expected_q.push_back(value);
        fork
            send_byte(value, 1'b1);
            expect_echoes(1);
        join
        @(posedge clk);
        #2;
        btn = 1'b1;
        check_led(value);  // last received byte.
        @(posedge clk);
        #2;
        btn = 1'b0;
        check_led(sw);
    endtask

    // back to back frames with the echo one frame behind.
    task automatic test_echo();
        core_pkg::uart_byte_t value;
        fork
            for (int i = 0; i < 20; i++) begin
                value = random_byte();
                expected_q.push_back(value);
                send_byte(value, 1'b1);
            end
            expect_echoes(20);
        join
    endtask

    task automatic test_frame_error();
        core_pkg::uart_byte_t value;
        fork
            begin
                value = random_byte();
                expected_q.push_back(value);
                send_byte(value, 1'b1);
                send_byte(random_byte(), 1'b0);  // low stop bit is discarded.
                value = random_byte();
                expected_q.push_back(value);
                send_byte(value, 1'b1);
            end
            expect_echoes(2);
        join
        expect_quiet();
    endtask

    task automatic test_flow_control();
        core_pkg::uart_byte_t value;
        set_rts(1'b1);
        for (int i = 0; i < 12; i++) begin
            value = random_byte();
            expected_q.push_back(value);
            send_byte(value, 1'b1);
            @(negedge clk);
            check_flag("uart_cts", (i == 11), uart_cts);  // high from the 12th byte.
        end
        set_rts(1'b0);
        expect_echoes(12);
        @(negedge clk);
        check_flag("uart_cts", 1'b0, uart_cts);
    endtask

    // 20 into a 16-deep fifo loses the last four.
    task automatic test_overrun();
        core_pkg::uart_byte_t value;
        set_rts(1'b1);
        for (int i = 0; i < 20; i++) begin
            value = random_byte();
            if (i < core_pkg::FIFO_DEPTH) begin
                expected_q.push_back(value);
            end
            send_byte(value, 1'b1);
        end
        @(posedge clk);
        #2;
        btn = 1'b1;
        check_led(value);  // register loads even on a dropped byte.
        @(posedge clk);
        #2;
        btn = 1'b0;
        set_rts(1'b0);
        expect_echoes(core_pkg::FIFO_DEPTH);
        expect_quiet();
    endtask

    initial begin
        rst_n          = 1'b0;
        btn            = 1'b0;
        sw             = 8'h00;
        uart_txd       = 1'b1;  // idle line.
        uart_rts       = 1'b0;  // host ready.
        line_must_idle = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_gpio();
        test_echo();
        test_frame_error();
        test_flow_control();
        test_overrun();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/fpga_core.sv
// board core logic: gpio to leds, uart echo through receiver, fifo and transmitter.
`timescale 1ns/10ps
`default_nettype none

module fpga_core (
    input  wire logic       clk,       // 125 mhz core clock.
    input  wire logic       rst_n,     // async reset, active low.

    // gpio.
    input  wire logic       btn,       // shows the last byte while held.
    input  wire logic [7:0] sw,
    output logic      [7:0] led,

    // uart, 115200 8n1, names seen from the host side.
    input  wire logic       uart_txd,  // serial data from host.
    output logic            uart_rxd,  // serial data to host.
    input  wire logic       uart_rts,  // host ready, active low.
    output logic            uart_cts   // core ready, active low.
);

    core_pkg::byte_strobe_t rx_byte;    // receiver to fifo.
    core_pkg::byte_strobe_t head;       // fifo to transmitter.
    logic                   pop;        // transmitter takes the head.
    core_pkg::uart_byte_t   last_byte;  // most recent received byte.

    // serial input side.
    uart_rx uart_rx_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .rxd     (uart_txd),
        .rx_byte (rx_byte)
    );

    // buffer between the two directions.
    echo_fifo echo_fifo_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (rx_byte),
        .head  (head),
        .pop   (pop),
        .cts   (uart_cts)
    );

    // serial output side, gated by the host's rts.
    uart_tx uart_tx_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .head  (head),
        .pop   (pop),
        .rts   (uart_rts),
        .txd   (uart_rxd)
    );

    // loads on every good byte, even one the fifo drops.
    always_ff @(posedge clk) begin
        if (rx_byte.stb) begin
            last_byte <= rx_byte.data;
        end
    end

    // led source select.
    assign led = btn ? last_byte : sw;

endmodule

`default_nettype wire

// File: hdl/echo_fifo.sv
// byte fifo between uart receiver and transmitter, drop on full, cts from fill level.
`timescale 1ns/10ps
`default_nettype none

module echo_fifo (
    input  wire logic                   clk,    // core clock.
    input  wire logic                   rst_n,  // async reset, active low.
    input  wire core_pkg::byte_strobe_t wr,     // write strobe and byte.
    output core_pkg::byte_strobe_t      head,   // oldest entry, stb when non-empty.
    input  wire logic                   pop,    // removes the head entry.
    output logic                        cts     // clear to send, active low.
);

    core_pkg::uart_byte_t mem [core_pkg::FIFO_DEPTH];  // storage, no reset.
    core_pkg::fifo_ptr_t  wr_ptr;                      // next free slot.
    core_pkg::fifo_ptr_t  rd_ptr;                      // oldest entry.
    core_pkg::fifo_cnt_t  count;                       // entries held.
    logic                 full;
    logic                 empty;
    logic                 do_wr;                       // accepted write.
    logic                 do_rd;                       // accepted pop.

    assign full  = (count == core_pkg::fifo_cnt_t'(core_pkg::FIFO_DEPTH));
    assign empty = (count == '0);

    // a strobe while full is simply lost, there is no back-pressure.
    assign do_wr = wr.stb && !full;
    assign do_rd = pop && !empty;

    // storage write.
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr.data;
        end
    end

    // pointers and fill count.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at the depth.
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither.
            endcase
        end
    end

    // head sees a new entry the cycle after its write.
    assign head = '{stb: !empty, data: mem[rd_ptr]};

    // host must stop once the fifo is nearly full.
    assign cts = (count >= core_pkg::fifo_cnt_t'(core_pkg::CTS_LEVEL));

endmodule

`default_nettype wire

// File: hdl/uart_tx.sv
// 8n1 uart transmitter that pops bytes from the echo fifo under rts flow control.
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
    input  wire logic                   clk,    // core clock.
    input  wire logic                   rst_n,  // async reset, active low.
    input  wire core_pkg::byte_strobe_t head,   // fifo head, stb means non-empty.
    output logic                        pop,    // one-cycle take of the head byte.
    input  wire logic                   rts,    // host ready, active low.
    output logic                        txd     // serial output, idle high.
);

    core_pkg::tx_state_e  state;         // framing fsm.
    logic [15:0]          prescale_cnt;  // cycles left to the next tick.
    logic [2:0]           tick_cnt;      // tick position inside a bit.
    logic [2:0]           bit_cnt;       // data bit index.
    core_pkg::uart_byte_t shreg;         // remaining data bits.
    logic                 tick;          // one oversample tick.
    logic                 bit_end;       // last tick of the current bit.

    // start only from idle, so rts never cuts a byte short.
    assign pop = (state == core_pkg::TX_IDLE) && head.stb && !rts;

    assign tick    = (prescale_cnt == 16'd0);
    assign bit_end = tick && (tick_cnt == 3'd7);  // eight ticks per bit.

    // bit timing, restarted with every byte.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prescale_cnt <= core_pkg::PRESCALE - 16'd1;
            tick_cnt     <= 3'd0;
        end else if (state == core_pkg::TX_IDLE) begin
            prescale_cnt <= core_pkg::PRESCALE - 16'd1;
            tick_cnt     <= 3'd0;
        end else if (tick) begin
            prescale_cnt <= core_pkg::PRESCALE - 16'd1;
            tick_cnt     <= tick_cnt + 3'd1;
        end else begin
            prescale_cnt <= prescale_cnt - 16'd1;
        end
    end

    // framing fsm, drives the line one bit at a time.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= core_pkg::TX_IDLE;
            bit_cnt <= 3'd0;
            txd     <= 1'b1;
        end else begin
            case (state)
                core_pkg::TX_IDLE: begin
                    txd <= 1'b1;
                    if (pop) begin
                        txd   <= 1'b0;  // start bit from the next cycle.
                        state <= core_pkg::TX_START;
                    end
                end
                core_pkg::TX_START: begin
                    if (bit_end) begin
                        txd     <= shreg[0];  // bit 0.
                        bit_cnt <= 3'd0;
                        state   <= core_pkg::TX_DATA;
                    end
                end
                core_pkg::TX_DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == 3'd7) begin
                            txd   <= 1'b1;  // stop bit.
                            state <= core_pkg::TX_STOP;
                        end else begin
                            txd     <= shreg[0];
                            bit_cnt <= bit_cnt + 3'd1;
                        end
                    end
                end
                core_pkg::TX_STOP: begin
                    if (bit_end) begin
                        state <= core_pkg::TX_IDLE;  // full stop bit sent.
                    end
                end
                default: begin
                    state <= core_pkg::TX_IDLE;
                end
            endcase
        end
    end

    // payload, loaded on pop and shifted at each bit boundary.
    always_ff @(posedge clk) begin
        if (pop) begin
            shreg <= head.data;
        end else if (bit_end && ((state == core_pkg::TX_START) ||
                                 (state == core_pkg::TX_DATA))) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

endmodule

`default_nettype wire

// File: hdl/uart_rx.sv
// 8n1 uart receiver with input synchronizer, 8x oversampling and framing check.
`timescale 1ns/10ps
`default_nettype none

module uart_rx (
    input  wire logic              clk,      // core clock.
    input  wire logic              rst_n,    // async reset, active low.
    input  wire logic              rxd,      // serial input, idle high.
    output core_pkg::byte_strobe_t rx_byte   // one-cycle strobe per good byte.
);

    logic                 rxd_meta;      // first synchronizer stage.
    logic                 rxd_sync;      // second stage, safe to use.
    logic                 rxd_prev;      // delayed copy for edge detect.
    logic                 start_edge;    // falling edge on the line.
    core_pkg::rx_state_e  state;         // framing fsm.
    logic [15:0]          prescale_cnt;  // cycles left to the next tick.
    logic [2:0]           tick_cnt;      // tick position inside a bit.
    logic [2:0]           bit_cnt;       // data bit index.
    core_pkg::uart_byte_t shreg;         // data bits, shifted in lsb first.
    logic                 rx_stb;        // registered output strobe.
    logic                 tick;          // one oversample tick.
    logic                 mid;           // middle tick of the current bit.

    // bring the line into the clock domain, reset to the idle level.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign start_edge = rxd_prev && !rxd_sync;  // high to low.

    // a low stop bit leaves the line low, so only a fresh edge restarts the fsm.

    assign tick = (prescale_cnt == 16'd0);
    assign mid  = tick && (tick_cnt == 3'd3);    // fourth tick is half a bit in.

    // oversample timing, held at its start value while idle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prescale_cnt <= core_pkg::PRESCALE - 16'd1;
            tick_cnt     <= 3'd0;
        end else if (state == core_pkg::RX_IDLE) begin
            prescale_cnt <= core_pkg::PRESCALE - 16'd1;
            tick_cnt     <= 3'd0;
        end else if (tick) begin
            prescale_cnt <= core_pkg::PRESCALE - 16'd1;  // reload.
            tick_cnt     <= tick_cnt + 3'd1;             // wraps every bit.
        end else begin
            prescale_cnt <= prescale_cnt - 16'd1;
        end
    end

    // framing fsm.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= core_pkg::RX_IDLE;
            bit_cnt <= 3'd0;
            rx_stb  <= 1'b0;
        end else begin
            rx_stb <= 1'b0;  // strobe lasts one cycle.
            case (state)
                core_pkg::RX_IDLE: begin
                    if (start_edge) begin
                        state <= core_pkg::RX_START;
                    end
                end
                core_pkg::RX_START: begin
                    if (mid) begin
                        if (rxd_sync) begin
                            state <= core_pkg::RX_IDLE;  // glitch, not a start bit.
                        end else begin
                            bit_cnt <= 3'd0;
                            state   <= core_pkg::RX_DATA;
                        end
                    end
                end
                core_pkg::RX_DATA: begin
                    if (mid) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= core_pkg::RX_STOP;  // last data bit taken.
                        end
                    end
                end
                core_pkg::RX_STOP: begin
                    if (mid) begin
                        rx_stb <= rxd_sync;  // bad stop bit gives no strobe.
                        state  <= core_pkg::RX_IDLE;
                    end
                end
                default: begin
                    state <= core_pkg::RX_IDLE;
                end
            endcase
        end
    end

    // data shift register, lsb arrives first.
    always_ff @(posedge clk) begin
        if ((state == core_pkg::RX_DATA) && mid) begin
            shreg <= {rxd_sync, shreg[7:1]};
        end
    end

    // shreg is stable from the stop bit until the next data bit.
    assign rx_byte = '{stb: rx_stb, data: shreg};

endmodule

`default_nettype wire

// File: hdl/core_pkg.sv
// shared constants, byte and strobe types, fifo types and uart state enums.
`default_nettype none

package core_pkg;

    // board clock and serial line rate.
    localparam int CLK_FREQ = 125_000_000;  // core clock in hertz.
    localparam int BAUD     = 115_200;      // uart bit rate.

    // clock cycles per oversample tick, eight ticks per bit.
    localparam logic [15:0] PRESCALE = 16'(CLK_FREQ / BAUD / 8);

    // echo fifo sizing.
    localparam int FIFO_DEPTH = 16;                  // number of byte entries.
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);  // pointer width.
    localparam int CTS_LEVEL  = 12;                  // fill level that deasserts cts.

    typedef logic [FIFO_AW-1:0] fifo_ptr_t;  // read and write pointer.
    typedef logic [FIFO_AW:0]   fifo_cnt_t;  // fill count, holds 0 to FIFO_DEPTH.

    // one data byte on the serial line.
    typedef logic [7:0] uart_byte_t;

    // byte with a qualifier bit.
    // rx to fifo the bit is a one-cycle strobe, fifo to tx it means valid.
    typedef struct packed {
        logic       stb;   // strobe or valid.
        uart_byte_t data;  // payload byte.
    } byte_strobe_t;

    // receiver states.
    typedef enum logic [1:0] {
        RX_IDLE,   // waiting for a falling edge.
        RX_START,  // checking the start bit at mid-bit.
        RX_DATA,   // shifting in eight data bits.
        RX_STOP    // checking the stop bit.
    } rx_state_e;

    // transmitter states.
    typedef enum logic [1:0] {
        TX_IDLE,   // line high, waiting for a byte.
        TX_START,  // driving the start bit.
        TX_DATA,   // driving data bits, lsb first.
        TX_STOP    // holding the stop bit for a full bit time.
    } tx_state_e;

endpackage

`default_nettype wire
